// File: source/cic_pkg.sv
`default_nettype none

package cic_pkg;

	// ------------------------------
	// helpers
	// ------------------------------

	// ceiling of log2, for counter and address sizing
	function automatic int clog2_f(input int value);
		int result;
		result = 0;
		while ((1 << result) < value)
			result = result + 1;
		return result;
	endfunction

	// ------------------------------
	// comb register file addressing
	// ------------------------------

	// channel codes
	localparam logic CHAN_I = 1'b0;
	localparam logic CHAN_Q = 1'b1;

	// comb = stage output, prev = delayed stage input
	localparam logic KIND_COMB = 1'b0;
	localparam logic KIND_PREV = 1'b1;

	// 4 bits covers stages 0..14 plus the exit states of the sequencer
	localparam int STAGE_BITS = 4;
	localparam int ADDR_BITS = STAGE_BITS + 2;

	typedef struct packed {
		logic channel;
		logic kind;
		logic [STAGE_BITS-1:0] stage;
	} comb_addr_fields_t;

	// sequencer fills the fields, register file indexes with raw
	typedef union packed {
		comb_addr_fields_t fields;
		logic [ADDR_BITS-1:0] raw;
	} comb_addr_t;

	// write data select codes
	localparam logic [1:0] SEL_INTEG = 2'd0;
	localparam logic [1:0] SEL_DIFF = 2'd1;
	localparam logic [1:0] SEL_OPERAND = 2'd2;

endpackage

`default_nettype wire

// File: source/cic_integ_chain.sv
`default_nettype none

module cic_integ_chain #(
	parameter int STAGES = 3,
	parameter int DECIMATION = 8,
	parameter int IN_WIDTH = 12,
	parameter int ACC_WIDTH = 21
) (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic in_strobe,
	input wire logic signed [IN_WIDTH-1:0] in_i,
	input wire logic signed [IN_WIDTH-1:0] in_q,
	output logic signed [ACC_WIDTH-1:0] integ_i,
	output logic signed [ACC_WIDTH-1:0] integ_q,
	output logic dec_strobe
);

	// one spare bit so a ratio of 1 still gets a counter
	localparam int CNT_W = cic_pkg::clog2_f(DECIMATION + 1);
	localparam logic [CNT_W-1:0] LAST_SAMPLE = CNT_W'(DECIMATION - 1);

	logic signed [ACC_WIDTH-1:0] acc_i [STAGES];
	logic signed [ACC_WIDTH-1:0] acc_q [STAGES];
	logic signed [ACC_WIDTH-1:0] ext_i;
	logic signed [ACC_WIDTH-1:0] ext_q;
	logic [CNT_W-1:0] sample_cnt;

	// sign extend inputs to accumulator width
	assign ext_i = {{(ACC_WIDTH-IN_WIDTH){in_i[IN_WIDTH-1]}}, in_i};
	assign ext_q = {{(ACC_WIDTH-IN_WIDTH){in_q[IN_WIDTH-1]}}, in_q};

	// ------------------------------
	// integrators and sample counter
	// ------------------------------

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < STAGES; k++)
			begin
				acc_i[k] <= '0;
				acc_q[k] <= '0;
			end
			sample_cnt <= '0;
			dec_strobe <= 1'b0;
		end
		else
		begin
			dec_strobe <= 1'b0;
			if (in_strobe)
			begin
				// each stage adds the registered output of the one before, wrapping
				acc_i[0] <= acc_i[0] + ext_i;
				acc_q[0] <= acc_q[0] + ext_q;
				for (int k = 1; k < STAGES; k++)
				begin
					acc_i[k] <= acc_i[k] + acc_i[k-1];
					acc_q[k] <= acc_q[k] + acc_q[k-1];
				end
				// pulse after every DECIMATION-th sample
				if (sample_cnt == LAST_SAMPLE)
				begin
					sample_cnt <= '0;
					dec_strobe <= 1'b1;
				end
				else
					sample_cnt <= sample_cnt + 1'b1;
			end
		end
	end

	// last stage feeds the comb engine, stable until next in_strobe
	assign integ_i = acc_i[STAGES-1];
	assign integ_q = acc_q[STAGES-1];

endmodule

`default_nettype wire

// File: source/cic_comb_ram.sv
`default_nettype none

module cic_comb_ram #(
	parameter int ACC_WIDTH = 21
) (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic wr_en,
	input wire cic_pkg::comb_addr_t wr_addr,
	input wire cic_pkg::comb_addr_t rd_addr,
	input wire logic signed [ACC_WIDTH-1:0] wr_data,
	output logic signed [ACC_WIDTH-1:0] rd_data
);

	localparam int DEPTH = 1 << cic_pkg::ADDR_BITS;

	// comb and prev values, both channels
	logic signed [ACC_WIDTH-1:0] mem [DEPTH];

	// ------------------------------
	// write port
	// ------------------------------

	// cleared so the first decimated sample starts from zero history
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end
		else if (wr_en)
			mem[wr_addr.raw] <= wr_data;
	end

	// ------------------------------
	// read port
	// ------------------------------

	// asynchronous, so a read in the write cycle returns the old value
	assign rd_data = mem[rd_addr.raw];

endmodule

`default_nettype wire

// File: source/cic_comb_alu.sv
`default_nettype none

module cic_comb_alu #(
	parameter int ACC_WIDTH = 21,
	parameter int OUT_WIDTH = 16
) (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic load_integ,
	input wire logic load_operand,
	input wire logic round_en,
	input wire logic chan,
	input wire logic [1:0] wr_sel,
	input wire logic signed [ACC_WIDTH-1:0] integ_i,
	input wire logic signed [ACC_WIDTH-1:0] integ_q,
	input wire logic signed [ACC_WIDTH-1:0] rd_data,
	output logic signed [ACC_WIDTH-1:0] wr_data,
	output logic signed [OUT_WIDTH-1:0] out_data
);

	logic signed [ACC_WIDTH-1:0] integ_q_hold;
	logic signed [ACC_WIDTH-1:0] operand;
	logic signed [ACC_WIDTH-1:0] diff;
	logic [OUT_WIDTH-1:0] top_bits;
	logic round_bit;

	// ------------------------------
	// operand and q sample registers
	// ------------------------------

	// q sampled together with i, used later in the q pass
	always_ff @(posedge clock)
	begin
		if (load_integ)
			integ_q_hold <= integ_q;
		if (load_operand)
			operand <= rd_data;
	end

	// comb[k] = t - prev[k], wraps at accumulator width
	assign diff = operand - rd_data;

	always_comb
	begin
		case (wr_sel)
			cic_pkg::SEL_INTEG:
				wr_data = (chan == cic_pkg::CHAN_Q) ? integ_q_hold : integ_i;
			cic_pkg::SEL_DIFF:
				wr_data = diff;
			default:
				wr_data = operand;
		endcase
	end

	// ------------------------------
	// output rounding
	// ------------------------------

	// top bits plus next lower bit, overflow wraps
	assign top_bits = rd_data[ACC_WIDTH-1 -: OUT_WIDTH];
	assign round_bit = rd_data[ACC_WIDTH-1-OUT_WIDTH];

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			out_data <= '0;
		else if (round_en)
			out_data <= $signed(top_bits + {{(OUT_WIDTH-1){1'b0}}, round_bit});
	end

endmodule

`default_nettype wire

// File: source/cic_comb_seq.sv
`default_nettype none

module cic_comb_seq #(
	parameter int STAGES = 3
) (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic dec_strobe,
	output cic_pkg::comb_addr_t rd_addr,
	output cic_pkg::comb_addr_t wr_addr,
	output logic wr_en,
	output logic load_integ,
	output logic load_operand,
	output logic round_en,
	output logic chan,
	output logic [1:0] wr_sel,
	output logic out_strobe_i,
	output logic out_strobe_q
);

	// stage counter runs 0..STAGES+2
	localparam int CNT_BITS = cic_pkg::STAGE_BITS + 1;
	localparam logic [CNT_BITS-1:0] LAST_CNT = CNT_BITS'(STAGES);
	localparam logic [CNT_BITS-1:0] EXIT_READ = CNT_BITS'(STAGES + 1);
	localparam logic [CNT_BITS-1:0] EXIT_ROUND = CNT_BITS'(STAGES + 2);

	// steps inside one comb stage
	localparam logic [1:0] STEP_LOAD = 2'd0;
	localparam logic [1:0] STEP_COMB = 2'd1;
	localparam logic [1:0] STEP_PREV = 2'd2;

	logic [CNT_BITS-1:0] stage_cnt;
	logic [CNT_BITS-1:0] stage_m1;
	logic [1:0] step;
	logic in_stage;
	logic go;

	function automatic cic_pkg::comb_addr_t make_addr(
		input logic ch,
		input logic kind,
		input logic [cic_pkg::STAGE_BITS-1:0] stage
	);
		cic_pkg::comb_addr_t a;
		a.fields.channel = ch;
		a.fields.kind = kind;
		a.fields.stage = stage;
		return a;
	endfunction

	assign stage_m1 = stage_cnt - 1'b1;
	assign in_stage = (stage_cnt != '0) && (stage_cnt <= LAST_CNT);
	// i pass waits for a new block, q pass follows at once
	assign go = dec_strobe || (chan == cic_pkg::CHAN_Q);

	// ------------------------------
	// control FSM
	// ------------------------------

	// each state registers its controls, the operation runs one cycle later
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stage_cnt <= '0;
			step <= STEP_LOAD;
			chan <= cic_pkg::CHAN_I;
			wr_en <= 1'b0;
			wr_addr <= '0;
			wr_sel <= cic_pkg::SEL_INTEG;
			load_integ <= 1'b0;
			load_operand <= 1'b0;
			round_en <= 1'b0;
			out_strobe_i <= 1'b0;
			out_strobe_q <= 1'b0;
		end
		else
		begin
			// single cycle pulses
			load_integ <= 1'b0;
			load_operand <= 1'b0;
			round_en <= 1'b0;
			out_strobe_i <= 1'b0;
			out_strobe_q <= 1'b0;

			if (stage_cnt == '0)
			begin
				// comb[0] = integ
				wr_en <= go;
				wr_addr <= make_addr(chan, cic_pkg::KIND_COMB, '0);
				wr_sel <= cic_pkg::SEL_INTEG;
				load_integ <= dec_strobe && (chan == cic_pkg::CHAN_I);
				step <= STEP_LOAD;
				if (go)
					stage_cnt <= stage_cnt + 1'b1;
			end
			else if (in_stage)
			begin
				if (step == STEP_LOAD)
				begin
					// t = comb[k-1]
					wr_en <= 1'b0;
					load_operand <= 1'b1;
					step <= STEP_COMB;
				end
				else if (step == STEP_COMB)
				begin
					// comb[k] = t - prev[k]
					wr_en <= 1'b1;
					wr_addr <= make_addr(chan, cic_pkg::KIND_COMB,
						stage_cnt[cic_pkg::STAGE_BITS-1:0]);
					wr_sel <= cic_pkg::SEL_DIFF;
					step <= STEP_PREV;
				end
				else
				begin
					// prev[k] = t, back to back with the comb write
					wr_en <= 1'b1;
					wr_addr <= make_addr(chan, cic_pkg::KIND_PREV,
						stage_cnt[cic_pkg::STAGE_BITS-1:0]);
					wr_sel <= cic_pkg::SEL_OPERAND;
					step <= STEP_LOAD;
					stage_cnt <= stage_cnt + 1'b1;
				end
			end
			else if (stage_cnt == EXIT_READ)
			begin
				// round comb[STAGES] next cycle
				wr_en <= 1'b0;
				round_en <= 1'b1;
				stage_cnt <= stage_cnt + 1'b1;
			end
			else
			begin
				// out_data is ready with the strobe
				wr_en <= 1'b0;
				if (chan == cic_pkg::CHAN_Q)
					out_strobe_q <= 1'b1;
				else
					out_strobe_i <= 1'b1;
				chan <= ~chan;
				stage_cnt <= '0;
			end
		end
	end

	// ------------------------------
	// read address
	// ------------------------------

	// serves the operation registered in the previous state
	always_comb
	begin
		rd_addr = make_addr(chan, cic_pkg::KIND_COMB, stage_cnt[cic_pkg::STAGE_BITS-1:0]);
		if (in_stage && (step == STEP_COMB))
			rd_addr = make_addr(chan, cic_pkg::KIND_COMB, stage_m1[cic_pkg::STAGE_BITS-1:0]);
		else if (in_stage && (step == STEP_PREV))
			rd_addr = make_addr(chan, cic_pkg::KIND_PREV,
				stage_cnt[cic_pkg::STAGE_BITS-1:0]);
		else if (stage_cnt == EXIT_ROUND)
			rd_addr = make_addr(chan, cic_pkg::KIND_COMB, LAST_CNT[cic_pkg::STAGE_BITS-1:0]);
	end

endmodule

`default_nettype wire

// File: source/cic_decim.sv
`default_nettype none

module cic_decim #(
	parameter int STAGES = 3,
	parameter int DECIMATION = 8,
	parameter int IN_WIDTH = 12,
	parameter int OUT_WIDTH = 16
) (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic in_strobe,
	input wire logic signed [IN_WIDTH-1:0] in_i,
	input wire logic signed [IN_WIDTH-1:0] in_q,
	output logic out_strobe_i,
	output logic out_strobe_q,
	output logic signed [OUT_WIDTH-1:0] out_data
);

	// bit growth N * log2(R)
	localparam int ACC_WIDTH = IN_WIDTH + STAGES * cic_pkg::clog2_f(DECIMATION);

	logic signed [ACC_WIDTH-1:0] integ_i;
	logic signed [ACC_WIDTH-1:0] integ_q;
	logic dec_strobe;

	cic_pkg::comb_addr_t rd_addr;
	cic_pkg::comb_addr_t wr_addr;
	logic wr_en;
	logic [1:0] wr_sel;
	logic load_integ;
	logic load_operand;
	logic round_en;
	logic chan;
	logic signed [ACC_WIDTH-1:0] wr_data;
	logic signed [ACC_WIDTH-1:0] rd_data;

	// ------------------------------
	// input rate integrators
	// ------------------------------

	cic_integ_chain #(
		.STAGES(STAGES),
		.DECIMATION(DECIMATION),
		.IN_WIDTH(IN_WIDTH),
		.ACC_WIDTH(ACC_WIDTH)
	) i_integ (
		.clock(clock),
		.rst_n(rst_n),
		.in_strobe(in_strobe),
		.in_i(in_i),
		.in_q(in_q),
		.integ_i(integ_i),
		.integ_q(integ_q),
		.dec_strobe(dec_strobe)
	);

	// ------------------------------
	// shared comb engine
	// ------------------------------

	cic_comb_seq #(
		.STAGES(STAGES)
	) i_seq (
		.clock(clock),
		.rst_n(rst_n),
		.dec_strobe(dec_strobe),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.wr_en(wr_en),
		.load_integ(load_integ),
		.load_operand(load_operand),
		.round_en(round_en),
		.chan(chan),
		.wr_sel(wr_sel),
		.out_strobe_i(out_strobe_i),
		.out_strobe_q(out_strobe_q)
	);

	cic_comb_alu #(
		.ACC_WIDTH(ACC_WIDTH),
		.OUT_WIDTH(OUT_WIDTH)
	) i_alu (
		.clock(clock),
		.rst_n(rst_n),
		.load_integ(load_integ),
		.load_operand(load_operand),
		.round_en(round_en),
		.chan(chan),
		.wr_sel(wr_sel),
		.integ_i(integ_i),
		.integ_q(integ_q),
		.rd_data(rd_data),
		.wr_data(wr_data),
		.out_data(out_data)
	);

	cic_comb_ram #(
		.ACC_WIDTH(ACC_WIDTH)
	) i_ram (
		.clock(clock),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.rd_addr(rd_addr),
		.wr_data(wr_data),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: sim/cic_decim_tb.sv
`default_nettype none

module cic_decim_tb;

	localparam int STAGES = 3;
	localparam int DECIMATION = 8;
	localparam int IN_W = 12;
	localparam int OUT_W = 16;
	localparam int ACC_W = IN_W + STAGES * $clog2(DECIMATION);
	localparam int CLK_PERIOD = 8;
	localparam int CYCLES_PER_SAMPLE = 4;
	localparam int PASS_CYCLES = 3 * STAGES + 3;
	localparam int DC_GAIN = DECIMATION ** STAGES;
	localparam int NUM_ROWS = 6;

	// row kinds
	localparam logic [3:0] K_PLAIN = 4'd0;
	localparam logic [3:0] K_DC = 4'd1;
	// sample patterns
	localparam logic [3:0] P_ZERO = 4'd0;
	localparam logic [3:0] P_CONST = 4'd1;
	localparam logic [3:0] P_IMPULSE = 4'd2;
	localparam logic [3:0] P_ALT = 4'd3;
	localparam logic [3:0] P_RAND = 4'd4;

	typedef struct packed {
		logic [3:0] kind;
		logic [3:0] i_pat;
		int i_amp;
		logic [3:0] q_pat;
		int q_amp;
		int samples;
		logic use_seed;
	} stim_row_t;

	logic clock;
	logic rst_n;
	logic in_strobe;
	logic signed [IN_W-1:0] in_i;
	logic signed [IN_W-1:0] in_q;
	logic out_strobe_i;
	logic out_strobe_q;
	logic signed [OUT_W-1:0] out_data;

	stim_row_t rows [NUM_ROWS];
	logic table_ready;
	int total_samples;
	logic [31:0] rng_state;

	// model state per channel with I at index 0 and Q at 1
	logic signed [ACC_W-1:0] integ_m [2][STAGES];
	logic signed [ACC_W-1:0] prev_m [2][STAGES];
	int dec_cnt_m;
	logic signed [OUT_W-1:0] exp_i [$];
	logic signed [OUT_W-1:0] exp_q [$];
	logic signed [OUT_W-1:0] last_exp [2];
	int count_i;
	int count_q;
	logic pending_q;

	cic_decim #(
		.STAGES(STAGES),
		.DECIMATION(DECIMATION),
		.IN_WIDTH(IN_W),
		.OUT_WIDTH(OUT_W)
	) i_dut (
		.clock(clock),
		.rst_n(rst_n),
		.in_strobe(in_strobe),
		.in_i(in_i),
		.in_q(in_q),
		.out_strobe_i(out_strobe_i),
		.out_strobe_q(out_strobe_q),
		.out_data(out_data)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// ------------------------------
	// failure reporting
	// ------------------------------

	task automatic stop_with_fail();
		$display("=== FAIL ===");
		$fatal(1, "testbench stopped");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		stop_with_fail();
	endtask

	task automatic check_value(input logic signed [63:0] got,
		input logic signed [63:0] expected, input string what);
		if (got !== expected)
		begin
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, expected);
			stop_with_fail();
		end
	endtask

	// ------------------------------
	// software CIC model
	// ------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// keep the top OUT_W bits and add the first dropped bit with wrap
	function automatic logic signed [OUT_W-1:0] round_acc(input logic signed [ACC_W-1:0] v);
		longint wide;
		longint rounded;
		wide = v;
		rounded = (wide >>> (ACC_W - OUT_W)) + ((wide >>> (ACC_W - OUT_W - 1)) & 1);
		return OUT_W'(rounded);
	endfunction

	// each stage adds the old value of the stage before it
	function automatic void integrate(input int ch, input logic signed [IN_W-1:0] x);
		for (int k = STAGES - 1; k > 0; k--)
			integ_m[ch][k] = integ_m[ch][k] + integ_m[ch][k-1];
		integ_m[ch][0] = integ_m[ch][0] + x;
	endfunction

	// D = 1 comb cascade at the decimated rate
	function automatic logic signed [ACC_W-1:0] comb_cascade(input int ch,
		input logic signed [ACC_W-1:0] v);
		logic signed [ACC_W-1:0] cur;
		logic signed [ACC_W-1:0] diff;
		cur = v;
		for (int k = 0; k < STAGES; k++)
		begin
			diff = cur - prev_m[ch][k];
			prev_m[ch][k] = cur;
			cur = diff;
		end
		return cur;
	endfunction

	task automatic model_step(input logic signed [IN_W-1:0] xi, input logic signed [IN_W-1:0] xq);
		integrate(0, xi);
		integrate(1, xq);
		dec_cnt_m = dec_cnt_m + 1;
		// every R-th sample yields one I and one Q result
		if (dec_cnt_m == DECIMATION)
		begin
			dec_cnt_m = 0;
			last_exp[0] = round_acc(comb_cascade(0, integ_m[0][STAGES-1]));
			last_exp[1] = round_acc(comb_cascade(1, integ_m[1][STAGES-1]));
			exp_i.push_back(last_exp[0]);
			exp_q.push_back(last_exp[1]);
		end
	endtask

	// ------------------------------
	// stimulus table
	// ------------------------------

	function automatic stim_row_t make_row(input logic [3:0] kind, input logic [3:0] i_pat,
		input int i_amp, input logic [3:0] q_pat, input int q_amp, input int samples,
		input logic use_seed);
		stim_row_t row;
		row.kind = kind;
		row.i_pat = i_pat;
		row.i_amp = i_amp;
		row.q_pat = q_pat;
		row.q_amp = q_amp;
		row.samples = samples;
		row.use_seed = use_seed;
		return row;
	endfunction

	task automatic fill_table();
		// first row starts from reset state
		rows[0] = make_row(K_DC, P_CONST, 100, P_CONST, -300, 64, 1'b0);
		rows[1] = make_row(K_DC, P_CONST, 1000, P_CONST, -1500, 64, 1'b0);
		// zero flush before an impulse on I only
		rows[2] = make_row(K_PLAIN, P_ZERO, 0, P_ZERO, 0, 48, 1'b0);
		rows[3] = make_row(K_PLAIN, P_IMPULSE, 2047, P_ZERO, 0, 64, 1'b0);
		// full scale swings and random data make the integrators wrap
		rows[4] = make_row(K_PLAIN, P_ALT, 2047, P_ALT, -2048, 64, 1'b0);
		rows[5] = make_row(K_PLAIN, P_RAND, 0, P_RAND, 0, 256, 1'b1);
		total_samples = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total_samples = total_samples + rows[r].samples;
	endtask

	task automatic pattern_value(input logic [3:0] pat, input int amp, input int n,
		output logic signed [IN_W-1:0] x);
		case (pat)
			P_CONST:
				x = IN_W'(amp);
			P_IMPULSE:
				x = (n == 0) ? IN_W'(amp) : '0;
			P_ALT:
				x = n[0] ? ~IN_W'(amp) : IN_W'(amp);
			P_RAND:
			begin
				rng_state = xorshift32(rng_state);
				x = rng_state[IN_W-1:0];
			end
			default:
				x = '0;
		endcase
	endtask

	// one strobe followed by idle cycles up to CYCLES_PER_SAMPLE
	task automatic drive_sample(input logic signed [IN_W-1:0] xi, input logic signed [IN_W-1:0] xq);
		@(posedge clock);
		in_strobe <= 1'b1;
		in_i <= xi;
		in_q <= xq;
		model_step(xi, xq);
		@(posedge clock);
		in_strobe <= 1'b0;
		repeat (CYCLES_PER_SAMPLE - 2) @(posedge clock);
	endtask

	task automatic run_row(input stim_row_t row);
		logic signed [IN_W-1:0] xi;
		logic signed [IN_W-1:0] xq;
		if (row.use_seed)
			rng_state = 32'd31811;
		for (int n = 0; n < row.samples; n++)
		begin
			pattern_value(row.i_pat, row.i_amp, n, xi);
			pattern_value(row.q_pat, row.q_amp, n, xq);
			drive_sample(xi, xq);
		end
		// settled dc is amp * R^N and its dropped low bits are zero here
		if (row.kind == K_DC)
		begin
			check_value(last_exp[0], (row.i_amp * DC_GAIN) / (1 << (ACC_W - OUT_W)), "I DC");
			check_value(last_exp[1], (row.q_amp * DC_GAIN) / (1 << (ACC_W - OUT_W)), "Q DC");
		end
	endtask

	// ------------------------------
	// output monitor
	// ------------------------------

	// strobes and data are stable at mid cycle
	always @(negedge clock)
	begin
		logic signed [OUT_W-1:0] want;
		if (rst_n === 1'b1)
		begin
			if (out_strobe_i && out_strobe_q)
				abort_run("out_strobe_i and out_strobe_q were high in the same cycle");
			else if (out_strobe_i)
			begin
				if (pending_q)
					abort_run("out_strobe_i came again before the Q result");
				else if (exp_i.size() == 0)
					abort_run("out_strobe_i came with no decimated block pending");
				else
				begin
					want = exp_i.pop_front();
					check_value(out_data, want, "I output");
					count_i = count_i + 1;
					pending_q = 1'b1;
				end
			end
			else if (out_strobe_q)
			begin
				if (!pending_q)
					abort_run("out_strobe_q came without an I result before it");
				else
				begin
					want = exp_q.pop_front();
					check_value(out_data, want, "Q output");
					count_q = count_q + 1;
					pending_q = 1'b0;
				end
			end
		end
	end

	// ------------------------------
	// watchdog
	// ------------------------------

	// 32 cycles per decimated block plus margin
	initial
	begin
		longint limit;
		wait (table_ready === 1'b1);
		limit = (longint'(total_samples / DECIMATION) * 32 + 400) * CLK_PERIOD;
		#(limit);
		abort_run("watchdog expired, the run hung waiting for output strobes");
	end

	// ------------------------------
	// main sequence
	// ------------------------------

	initial
	begin
		rst_n = 1'b0;
		in_strobe = 1'b0;
		in_i = '0;
		in_q = '0;
		table_ready = 1'b0;
		rng_state = 32'd31811;
		for (int c = 0; c < 2; c++)
		begin
			for (int k = 0; k < STAGES; k++)
			begin
				integ_m[c][k] = '0;
				prev_m[c][k] = '0;
			end
			last_exp[c] = '0;
		end
		dec_cnt_m = 0;
		count_i = 0;
		count_q = 0;
		pending_q = 1'b0;
		fill_table();
		table_ready = 1'b1;

		repeat (3) @(posedge clock);
		rst_n <= 1'b1;

		// post reset outputs
		@(negedge clock);
		check_value(out_strobe_i, 0, "out_strobe_i after reset");
		check_value(out_strobe_q, 0, "out_strobe_q after reset");
		check_value(out_data, 0, "out_data after reset");

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(rows[r]);

		// drain the queues and leave time for stray strobes
		while (exp_i.size() != 0 || exp_q.size() != 0)
			@(posedge clock);
		repeat (4 * PASS_CYCLES) @(posedge clock);

		check_value(count_i, total_samples / DECIMATION, "out_strobe_i count");
		check_value(count_q, total_samples / DECIMATION, "out_strobe_q count");
		check_value(pending_q, 0, "Q result missing after last I");
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
source/cic_pkg.sv
source/cic_integ_chain.sv
source/cic_comb_ram.sv
source/cic_comb_alu.sv
source/cic_comb_seq.sv
source/cic_decim.sv
sim/cic_decim_tb.sv

// File: Bender.yml
package:
  name: cic_decim

sources:
  # package
  - files:
      - source/cic_pkg.sv
  # RTL
  - files:
      - source/cic_integ_chain.sv
      - source/cic_comb_ram.sv
      - source/cic_comb_alu.sv
      - source/cic_comb_seq.sv
      - source/cic_decim.sv
  # testbench
  - target: simulation
    files:
      - sim/cic_decim_tb.sv
